// ==== vlog.f ====
hdl/rob_pkg.sv
hdl/dispatch_unit.sv
hdl/exec_lane.sv
hdl/completion_arbiter.sv
hdl/reorder_buffer.sv
hdl/ooo_core_top.sv
verif/tb_ooo_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reorder-buffer core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_ooo_core

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_ooo_core -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

// ==== verif/tb_ooo_core.sv ====
module tb_ooo_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     CLK_PERIOD = 4;
    localparam int     DRIVE_DLY  = 1;                   // Input skew after the rising edge
    localparam int     N_TOTAL    = 12 + 12 + 40 + 10 + 300;
    localparam int     OVF_GAP    = 12;                  // Quiet ops between two random traps
    localparam longint S32_MAX    = 64'sh0000_0000_7fff_ffff;
    localparam longint S32_MIN    = 64'shffff_ffff_8000_0000;

    logic             clk;
    logic             rst;
    logic             in_req;
    rob_pkg::inst_t   in_inst;
    logic             in_ack;
    logic             commit_valid;
    rob_pkg::commit_t commit;

    rob_pkg::commit_t exp_q [$];                         // Expected records in program order
    logic [31:0]      lcg_state = 32'h1e9031c6;
    int               n_sent = 0;
    int               n_commit = 0;
    int               n_flushed = 0;
    logic             ack_q = 1'b0;
    logic             req_q = 1'b0;

    ooo_core_top dut (
        .clk          (clk),
        .rst          (rst),
        .in_req       (in_req),
        .in_inst      (in_inst),
        .in_ack       (in_ack),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected retirement record straight from the ISA rules
    function automatic rob_pkg::commit_t ref_exec(input rob_pkg::inst_t inst);
        rob_pkg::commit_t res;
        longint           sa;
        longint           sb;
        longint           wide;
        logic             ovf;
        sa  = longint'($signed(inst.src_a));
        sb  = longint'($signed(inst.src_b));
        ovf = 1'b0;
        case (inst.op)
            rob_pkg::OP_ADD: begin
                wide      = sa + sb;                     // Exact sum without wrap
                ovf       = (wide > S32_MAX) || (wide < S32_MIN);
                res.value = wide[31:0];
            end
            rob_pkg::OP_SUB: begin
                wide      = sa - sb;
                ovf       = (wide > S32_MAX) || (wide < S32_MIN);
                res.value = wide[31:0];
            end
            rob_pkg::OP_AND: res.value = inst.src_a & inst.src_b;
            default:         res.value = inst.src_a * inst.src_b;  // Low 32 bits
        endcase
        res.dest      = inst.dest;
        res.exc       = ovf;
        res.reg_write = (inst.dest != '0) && !ovf;       // A trap writes nothing
        return res;
    endfunction

    function automatic rob_pkg::inst_t make_inst(input rob_pkg::op_e op, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [4:0] dest);
        rob_pkg::inst_t inst;
        inst.op    = op;
        inst.src_a = a;
        inst.src_b = b;
        inst.dest  = dest;
        return inst;
    endfunction

    // Small operands never overflow, wide ones may
    function automatic rob_pkg::inst_t rand_inst(input int op_span, input bit wide_ok);
        rob_pkg::inst_t inst;
        logic [31:0]    r;
        logic [31:0]    ta;
        logic [31:0]    tb;
        r          = lcg_next();
        ta         = lcg_next();
        tb         = lcg_next();
        inst.op    = rob_pkg::op_e'(2'(r[31:28] % 4'(op_span)));  // High LCG bits run longest
        inst.dest  = r[27:23];
        inst.src_a = {{16{ta[31]}}, ta[31:16]};
        inst.src_b = {{16{tb[31]}}, tb[31:16]};
        if (wide_ok && r[22:20] == 3'd0) begin
            inst.src_a = ta;
            inst.src_b = tb;
        end
        return inst;
    endfunction

    task automatic halt_fail(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        halt_fail($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_commit(input rob_pkg::commit_t got, input rob_pkg::commit_t exp);
        if (got.value !== exp.value)
            value_error("commit.value", got.value, exp.value);
        else if (got.dest !== exp.dest)
            value_error("commit.dest", 32'(got.dest), 32'(exp.dest));
        else if (got.reg_write !== exp.reg_write)
            value_error("commit.reg_write", 32'(got.reg_write), 32'(exp.reg_write));
        else if (got.exc !== exp.exc)
            value_error("commit.exc", 32'(got.exc), 32'(exp.exc));
    endtask

    // Four-phase transfer with the expected record queued at the ack edge
    task automatic send(input rob_pkg::inst_t inst);
        in_inst = inst;
        in_req  = 1'b1;
        do begin
            @(posedge clk);
            #(DRIVE_DLY);
        end while (!in_ack);
        exp_q.push_back(ref_exec(inst));
        n_sent++;
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #(DRIVE_DLY);
        end while (in_ack);
    endtask

    // Wait for retirement, then let stale lane work wash out
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #(DRIVE_DLY);
        end
        repeat (20) @(posedge clk);
        #(DRIVE_DLY);
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        rob_pkg::commit_t exp;
        if (!rst) begin
            if (in_ack && !ack_q && !req_q)
                halt_fail("Handshake violation: in_ack rose while in_req was low");
            ack_q <= in_ack;
            req_q <= in_req;                             // Request level ahead of the next edge
            if (commit_valid) begin
                if (exp_q.size() == 0) begin
                    halt_fail("Commit seen with no instruction outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    check_commit(commit, exp);
                    n_commit++;
                    if (exp.exc) begin
                        n_flushed += exp_q.size();       // Younger ops acked up to the flush
                        exp_q.delete();
                    end
                end
            end
        end
    end

    initial begin
        repeat (200 * N_TOTAL) @(posedge clk);
        halt_fail("Timeout: the run did not finish within the cycle budget");
    end

    initial begin
        rob_pkg::inst_t inst;
        rob_pkg::commit_t probe;
        int since_ovf;
        rst       = 1'b1;
        in_req    = 1'b0;
        in_inst   = '0;
        since_ovf = OVF_GAP;
        repeat (5) @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b0;

        for (int i = 0; i < 12; i++) send(rand_inst(3, 1'b0));   // Single-cycle ops only
        drain();

        for (int i = 0; i < 12; i++) begin
            inst = rand_inst(3, 1'b0);
            if (i % 2 == 0) inst.op = rob_pkg::OP_MUL;   // Slow op ahead of a fast one
            send(inst);
        end
        drain();

        for (int i = 0; i < 40; i++) send(rand_inst(4, 1'b0));   // Well past ROB depth
        drain();

        send(make_inst(rob_pkg::OP_MUL, 32'd1234, 32'd5678, 5'd1));  // Holds the head
        send(make_inst(rob_pkg::OP_ADD, 32'h7fff_ffff, 32'd1, 5'd3));
        send(make_inst(rob_pkg::OP_AND, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd4));
        send(make_inst(rob_pkg::OP_SUB, 32'd100, 32'd7, 5'd5));
        send(make_inst(rob_pkg::OP_MUL, 32'd3, 32'd11, 5'd6));
        send(make_inst(rob_pkg::OP_ADD, 32'd40, 32'd2, 5'd7));
        drain();
        send(make_inst(rob_pkg::OP_ADD, 32'd9, 32'd8, 5'd8));
        send(make_inst(rob_pkg::OP_SUB, 32'h8000_0000, 32'd0, 5'd9));
        send(make_inst(rob_pkg::OP_MUL, 32'hffff_ffff, 32'd2, 5'd10));
        send(make_inst(rob_pkg::OP_AND, 32'hdead_beef, 32'hffff_0000, 5'd0));
        drain();

        for (int i = 0; i < 300; i++) begin
            inst  = rand_inst(4, 1'b1);
            probe = ref_exec(inst);
            if (probe.exc && since_ovf < OVF_GAP)
                inst.op = rob_pkg::OP_AND;               // Keep traps spread apart
            probe     = ref_exec(inst);
            since_ovf = probe.exc ? 0 : since_ovf + 1;
            send(inst);
        end
        drain();

        $display("Sent %0d, committed %0d, flushed %0d", n_sent, n_commit, n_flushed);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== hdl/ooo_core_top.sv ====
module ooo_core_top #(
    parameter int ROB_DEPTH = 16,                        // Power of two, up to 2**TAG_W
    parameter int N_LANES   = 4                          // 1 to 8 lanes
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_req,
    input  rob_pkg::inst_t    in_inst,
    output logic              in_ack,
    output logic              commit_valid,
    output rob_pkg::commit_t  commit
);

    logic                          rob_full;
    logic [rob_pkg::TAG_W-1:0]     alloc_tag;
    logic                          alloc_epoch;
    logic                          alloc_valid;
    logic [rob_pkg::DEST_W-1:0]    alloc_dest;
    logic                          alloc_reg_write;
    logic [N_LANES-1:0]            lane_idle;
    logic [N_LANES-1:0]            issue_valid;          // One-hot lane select
    rob_pkg::lane_op_t             issue_op;             // Broadcast to all lanes
    logic [N_LANES-1:0]            lane_done;
    rob_pkg::cmpl_t [N_LANES-1:0]  lane_result;
    logic [N_LANES-1:0]            grant;
    logic                          cmpl_valid;
    rob_pkg::cmpl_t                cmpl;

    dispatch_unit #(.N_LANES(N_LANES)) u_dispatch (
        .clk             (clk),
        .rst             (rst),
        .in_req          (in_req),
        .in_inst         (in_inst),
        .in_ack          (in_ack),
        .rob_full        (rob_full),
        .alloc_tag       (alloc_tag),
        .alloc_epoch     (alloc_epoch),
        .alloc_valid     (alloc_valid),
        .alloc_dest      (alloc_dest),
        .alloc_reg_write (alloc_reg_write),
        .lane_idle       (lane_idle),
        .issue_valid     (issue_valid),
        .issue_op        (issue_op)
    );

    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        exec_lane u_lane (
            .clk         (clk),
            .rst         (rst),
            .issue_valid (issue_valid[g]),
            .issue_op    (issue_op),
            .lane_idle   (lane_idle[g]),
            .done        (lane_done[g]),
            .result      (lane_result[g]),
            .grant       (grant[g])
        );
    end

    completion_arbiter #(.N_LANES(N_LANES)) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .lane_done   (lane_done),
        .lane_result (lane_result),
        .grant       (grant),
        .cmpl_valid  (cmpl_valid),
        .cmpl        (cmpl)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk             (clk),
        .rst             (rst),
        .alloc_valid     (alloc_valid),
        .alloc_dest      (alloc_dest),
        .alloc_reg_write (alloc_reg_write),
        .alloc_tag       (alloc_tag),
        .alloc_epoch     (alloc_epoch),
        .rob_full        (rob_full),
        .cmpl_valid      (cmpl_valid),
        .cmpl            (cmpl),
        .commit_valid    (commit_valid),
        .commit          (commit)
    );

endmodule

// ==== hdl/reorder_buffer.sv ====
module reorder_buffer #(
    parameter int ROB_DEPTH = 16                         // Power of two, up to 2**TAG_W
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alloc_valid,
    input  logic [rob_pkg::DEST_W-1:0] alloc_dest,
    input  logic                       alloc_reg_write,
    output logic [rob_pkg::TAG_W-1:0]  alloc_tag,        // Tail slot, valid every cycle
    output logic                       alloc_epoch,
    output logic                       rob_full,
    input  logic                       cmpl_valid,
    input  rob_pkg::cmpl_t             cmpl,
    output logic                       commit_valid,     // One-cycle retire pulse
    output rob_pkg::commit_t           commit
);

    localparam int PTR_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;
    localparam int TAG_W = rob_pkg::TAG_W;

    logic [ROB_DEPTH-1:0]         ent_busy;              // Slot allocated
    logic [ROB_DEPTH-1:0]         ent_ready;             // Result written
    logic [ROB_DEPTH-1:0]         ent_exc;
    logic [ROB_DEPTH-1:0]         ent_reg_write;
    logic [rob_pkg::DEST_W-1:0]   ent_dest [ROB_DEPTH];
    logic [rob_pkg::DATA_W-1:0]   ent_value [ROB_DEPTH];

    logic [PTR_W-1:0]             head;                  // Oldest entry
    logic [PTR_W-1:0]             tail;                  // Next free slot
    logic [PTR_W:0]               count;
    logic                         epoch;                 // Flips on every flush

    logic [PTR_W-1:0]             cmpl_idx;
    logic                         cmpl_hit;              // Completion from the live epoch
    logic                         retire;
    logic                         flush;

    assign cmpl_idx = cmpl.tag[PTR_W-1:0];
    assign cmpl_hit = cmpl_valid && (cmpl.epoch == epoch);

    assign retire = ent_busy[head] && ent_ready[head];
    assign flush  = retire && ent_exc[head];             // Trapping op at the head

    assign alloc_tag   = TAG_W'(tail);
    assign alloc_epoch = epoch;
    assign rob_full    = (count == (PTR_W + 1)'(ROB_DEPTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_busy     <= '0;
            ent_ready    <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            epoch        <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            if (flush) begin
                // Drop every younger entry, an alloc at this edge included
                ent_busy  <= '0;
                ent_ready <= '0;
                head      <= '0;
                tail      <= '0;
                count     <= '0;
                epoch     <= ~epoch;                     // Stale lane results now miss
            end else begin
                if (alloc_valid) begin
                    ent_busy[tail]  <= 1'b1;
                    ent_ready[tail] <= 1'b0;
                    tail            <= tail + 1'b1;      // Wraps at depth
                end
                if (cmpl_hit) begin
                    ent_ready[cmpl_idx] <= 1'b1;
                end
                if (retire) begin
                    ent_busy[head]  <= 1'b0;
                    ent_ready[head] <= 1'b0;
                    head            <= head + 1'b1;
                end
                count <= count + (PTR_W + 1)'(alloc_valid) - (PTR_W + 1)'(retire);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_dest[tail]      <= alloc_dest;
            ent_reg_write[tail] <= alloc_reg_write;
        end
        if (cmpl_hit) begin
            ent_value[cmpl_idx] <= cmpl.value;
            ent_exc[cmpl_idx]   <= cmpl.exc;
        end
        if (retire) begin
            commit.value     <= ent_value[head];
            commit.dest      <= ent_dest[head];
            commit.reg_write <= ent_reg_write[head] && !ent_exc[head];  // Trap suppresses write
            commit.exc       <= ent_exc[head];
        end
    end

    // Dispatch holds off while the buffer reports full
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc_valid |-> !rob_full);

    // Live-epoch results only come back for slots still in flight
    a_cmpl_busy: assert property (@(posedge clk) disable iff (rst)
        cmpl_hit |-> ent_busy[cmpl_idx]);

endmodule

// ==== hdl/completion_arbiter.sv ====
module completion_arbiter #(
    parameter int N_LANES = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [N_LANES-1:0]            lane_done,
    input  rob_pkg::cmpl_t [N_LANES-1:0]  lane_result,
    output logic [N_LANES-1:0]            grant,         // Combinational, one lane per cycle
    output logic                          cmpl_valid,
    output rob_pkg::cmpl_t                cmpl
);

    localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    logic [PTR_W-1:0] rr_ptr;                            // Lane with top priority
    logic [PTR_W-1:0] win_idx;                           // Lane granted this cycle
    logic             found;

    // Scan from the pointer and wrap around
    always_comb begin
        int idx;
        grant   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < N_LANES; i++) begin
            idx = (int'(rr_ptr) + i) % N_LANES;
            if (!found && lane_done[idx]) begin
                found      = 1'b1;
                win_idx    = PTR_W'(idx);
                grant[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr     <= '0;
            cmpl_valid <= 1'b0;
        end else begin
            cmpl_valid <= found;
            if (found) begin
                rr_ptr <= PTR_W'((int'(win_idx) + 1) % N_LANES);  // Winner goes last
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            cmpl <= lane_result[win_idx];                // One register stage to the ROB
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant));

    // A waiting lane is served within one full rotation
    for (genvar k = 0; k < N_LANES; k++) begin : g_fair
        a_no_starve: assert property (@(posedge clk) disable iff (rst)
            lane_done[k] |-> ##[0:N_LANES-1] grant[k]);
    end

endmodule

// ==== hdl/exec_lane.sv ====
module exec_lane (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  rob_pkg::lane_op_t  issue_op,
    output logic               lane_idle,
    output logic               done,                     // Result valid, held until grant
    output rob_pkg::cmpl_t     result,
    input  logic               grant
);

    localparam int CNT_W = (rob_pkg::MUL_CYCLES > 2) ? $clog2(rob_pkg::MUL_CYCLES) : 1;

    logic                        busy;                   // Op held, running or finished
    logic [CNT_W-1:0]            mul_cnt;                // MUL cycles still to go
    rob_pkg::lane_op_t           op_q;                   // Operands kept for the whole op
    logic [rob_pkg::DATA_W-1:0]  sum;
    logic [rob_pkg::DATA_W-1:0]  diff;
    logic [rob_pkg::DATA_W-1:0]  prod;
    logic                        ovf_add;
    logic                        ovf_sub;

    assign sum  = op_q.src_a + op_q.src_b;
    assign diff = op_q.src_a - op_q.src_b;
    assign prod = op_q.src_a * op_q.src_b;               // Low half only

    // Same-sign inputs with a flipped result sign
    assign ovf_add = (op_q.src_a[31] == op_q.src_b[31]) && (sum[31] != op_q.src_a[31]);
    assign ovf_sub = (op_q.src_a[31] != op_q.src_b[31]) && (diff[31] != op_q.src_a[31]);

    assign lane_idle = !busy;

    always_comb begin
        result.tag   = op_q.tag;
        result.epoch = op_q.epoch;
        result.exc   = 1'b0;
        case (op_q.op)
            rob_pkg::OP_ADD: begin
                result.value = sum;
                result.exc   = ovf_add;
            end
            rob_pkg::OP_SUB: begin
                result.value = diff;
                result.exc   = ovf_sub;
            end
            rob_pkg::OP_AND: result.value = op_q.src_a & op_q.src_b;
            default:         result.value = prod;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            mul_cnt <= '0;
        end else begin
            if (issue_valid) begin
                busy <= 1'b1;
                if (issue_op.op == rob_pkg::OP_MUL) begin
                    mul_cnt <= CNT_W'(rob_pkg::MUL_CYCLES - 1);  // Multi-cycle path
                end else begin
                    done <= 1'b1;                        // Single-cycle ops
                end
            end
            if (mul_cnt != '0) begin
                mul_cnt <= mul_cnt - 1'b1;
                if (mul_cnt == CNT_W'(1)) begin
                    done <= 1'b1;                        // Product settled
                end
            end
            if (grant) begin
                done <= 1'b0;                            // Drained, free for the next op
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            op_q <= issue_op;
        end
    end

    // Dispatch must only pick this lane while it reports idle
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !busy);

    a_mul_latency: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && issue_op.op == rob_pkg::OP_MUL) |-> ##(rob_pkg::MUL_CYCLES) done);

endmodule

// ==== hdl/dispatch_unit.sv ====
module dispatch_unit #(
    parameter int N_LANES = 4                            // Execution lanes to choose from
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_req,           // Four-phase request
    input  rob_pkg::inst_t             in_inst,          // Stable while in_req is high
    output logic                       in_ack,
    input  logic                       rob_full,
    input  logic [rob_pkg::TAG_W-1:0]  alloc_tag,        // ROB tail slot
    input  logic                       alloc_epoch,
    output logic                       alloc_valid,
    output logic [rob_pkg::DEST_W-1:0] alloc_dest,
    output logic                       alloc_reg_write,
    input  logic [N_LANES-1:0]         lane_idle,
    output logic [N_LANES-1:0]         issue_valid,
    output rob_pkg::lane_op_t          issue_op
);

    typedef enum logic {
        HS_WAIT_REQ,                                     // Ack low, waiting for a request
        HS_WAIT_DROP                                     // Ack high, waiting for req to fall
    } hs_state_e;

    hs_state_e          state;
    logic               accept;                          // Allocate and issue at this edge
    logic [N_LANES-1:0] lane_sel;                        // Lowest idle lane, one-hot

    // Two's complement trick keeps only the lowest set bit
    assign lane_sel = lane_idle & (~lane_idle + N_LANES'(1));

    assign accept = (state == HS_WAIT_REQ) && in_req && !rob_full && (|lane_idle);
    assign in_ack = (state == HS_WAIT_DROP);

    assign alloc_valid     = accept;
    assign alloc_dest      = in_inst.dest;
    assign alloc_reg_write = |in_inst.dest;              // r0 is never written

    assign issue_valid = accept ? lane_sel : '0;
    assign issue_op    = '{op:    in_inst.op,
                           src_a: in_inst.src_a,
                           src_b: in_inst.src_b,
                           tag:   alloc_tag,
                           epoch: alloc_epoch};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_WAIT_REQ;
        end else begin
            case (state)
                HS_WAIT_REQ: begin
                    if (accept) begin
                        state <= HS_WAIT_DROP;           // Raise ack once resources allow
                    end
                end
                HS_WAIT_DROP: begin
                    if (!in_req) begin
                        state <= HS_WAIT_REQ;            // Source let go, drop ack
                    end
                end
                default: state <= HS_WAIT_REQ;
            endcase
        end
    end

    // At most one lane takes an op per transfer
    a_issue_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(issue_valid));

endmodule

// ==== hdl/rob_pkg.sv ====
package rob_pkg;

    localparam int DATA_W     = 32;              // Operand and result width
    localparam int DEST_W     = 5;               // Architectural register index
    localparam int TAG_W      = 4;               // ROB tag, log2 of default depth
    localparam int MUL_CYCLES = 4;               // Fixed multiply latency, at least 2

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,                           // Signed add, traps on overflow
        OP_SUB = 2'd1,                           // Signed subtract, traps on overflow
        OP_AND = 2'd2,                           // Bitwise and
        OP_MUL = 2'd3                            // Low half of the product
    } op_e;

    // Instruction as it arrives on the external port
    typedef struct packed {
        op_e               op;
        logic [DATA_W-1:0] src_a;
        logic [DATA_W-1:0] src_b;
        logic [DEST_W-1:0] dest;                 // Zero means no register write
    } inst_t;

    // Work item handed from dispatch to one lane
    typedef struct packed {
        op_e               op;
        logic [DATA_W-1:0] src_a;
        logic [DATA_W-1:0] src_b;
        logic [TAG_W-1:0]  tag;                  // ROB slot of this op
        logic              epoch;                // ROB epoch at allocation
    } lane_op_t;

    // Finished lane result, written into the ROB by tag
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic              epoch;
        logic [DATA_W-1:0] value;
        logic              exc;                  // Signed overflow seen
    } cmpl_t;

    // Record leaving the ROB head at retirement
    typedef struct packed {
        logic [DATA_W-1:0] value;
        logic [DEST_W-1:0] dest;
        logic              reg_write;
        logic              exc;
    } commit_t;

endpackage
